// ==== Bender.yml ====
package:
  name: eprom_emulator

sources:
  - hdl/emu_pkg.sv
  - hdl/command_decoder.sv
  - hdl/sram_loader.sv
  - hdl/mode_control.sv
  - hdl/eprom_emulator_top.sv
  - target: simulation
    files:
      - verification/tb_eprom_emulator.sv

// ==== hdl/command_decoder.sv ====
module command_decoder (
    input  logic                clk24MHz,
    input  logic                rst_n,
    // FT240X receive side
    input  emu_pkg::fifo_byte_t ft240x_d,
    input  logic                ft240x_rxf,
    output logic                ft240x_rd_n,
    // Loader handshake
    input  logic                write_done,
    output logic                addr_clear,
    output logic                word_strobe,
    output emu_pkg::sram_word_t word,
    // Mode and status commands
    output logic                mode_strobe,
    output emu_pkg::mode_t      mode_sel,
    output logic                status_strobe,
    output logic                status_value
);

    emu_pkg::decoder_state_t state;
    // Words still to be fetched for the current WRITE
    emu_pkg::word_count_t    remaining;

    //////////////////////////////////////////////////
    // FIFO read strobe

    // RD# low for two cycles per byte, data sampled in the second
    always_comb begin
        case (state)
            emu_pkg::DEC_CMD_PRERX,
            emu_pkg::DEC_GETCMD,
            emu_pkg::DEC_HIGH_REQ,
            emu_pkg::DEC_HIGH_LATCH,
            emu_pkg::DEC_LOW_REQ,
            emu_pkg::DEC_LOW_LATCH: ft240x_rd_n = 1'b0;
            default:                ft240x_rd_n = 1'b1;
        endcase
    end

    //////////////////////////////////////////////////
    // Sequencer

    always_ff @(posedge clk24MHz) begin
        if (!rst_n) begin
            state         <= emu_pkg::DEC_NEXTCMD;
            remaining     <= '0;
            addr_clear    <= 1'b0;
            word_strobe   <= 1'b0;
            mode_strobe   <= 1'b0;
            status_strobe <= 1'b0;
        end else begin
            // Strobes are single-cycle pulses
            addr_clear    <= 1'b0;
            word_strobe   <= 1'b0;
            mode_strobe   <= 1'b0;
            status_strobe <= 1'b0;

            case (state)
                // Precharge, RXF may lag behind the last read
                emu_pkg::DEC_NEXTCMD: begin
                    state <= emu_pkg::DEC_WAITCMD;
                end

                emu_pkg::DEC_WAITCMD: begin
                    if (!ft240x_rxf) begin
                        state <= emu_pkg::DEC_CMD_PRERX;
                    end
                end

                // RD# active to valid data
                emu_pkg::DEC_CMD_PRERX: begin
                    state <= emu_pkg::DEC_GETCMD;
                end

                // Classify the command byte
                emu_pkg::DEC_GETCMD: begin
                    if (ft240x_d == emu_pkg::CMD_NOP) begin
                        state <= emu_pkg::DEC_NEXTCMD;
                    end else if (ft240x_d == emu_pkg::CMD_ADDR_RESET) begin
                        addr_clear <= 1'b1;
                        state      <= emu_pkg::DEC_NEXTCMD;
                    end else if (ft240x_d[7:4] == emu_pkg::CMD_SET_MODE_NIBBLE) begin
                        // Bits 3:2 ignored
                        mode_strobe <= 1'b1;
                        state       <= emu_pkg::DEC_NEXTCMD;
                    end else if (ft240x_d[7:4] == emu_pkg::CMD_WRITE_NIBBLE) begin
                        // Zero wraps to 16 words via the decrement
                        remaining <= ft240x_d[3:0];
                        state     <= emu_pkg::DEC_WAIT_HIGH;
                    end else if (ft240x_d == emu_pkg::CMD_LED_ON ||
                                 ft240x_d == emu_pkg::CMD_LED_OFF) begin
                        status_strobe <= 1'b1;
                        state         <= emu_pkg::DEC_NEXTCMD;
                    end else begin
                        // Unknown opcode, treated as NOP
                        state <= emu_pkg::DEC_NEXTCMD;
                    end
                end

                //////////////////////////////////////////////////
                // Word fetch, high byte first

                emu_pkg::DEC_WAIT_HIGH: begin
                    if (!ft240x_rxf) begin
                        state <= emu_pkg::DEC_HIGH_REQ;
                    end
                end

                emu_pkg::DEC_HIGH_REQ: begin
                    remaining <= remaining - 1'b1;
                    state     <= emu_pkg::DEC_HIGH_LATCH;
                end

                emu_pkg::DEC_HIGH_LATCH: begin
                    state <= emu_pkg::DEC_WAIT_LOW;
                end

                emu_pkg::DEC_WAIT_LOW: begin
                    if (!ft240x_rxf) begin
                        state <= emu_pkg::DEC_LOW_REQ;
                    end
                end

                emu_pkg::DEC_LOW_REQ: begin
                    state <= emu_pkg::DEC_LOW_LATCH;
                end

                // Word is complete on the next edge
                emu_pkg::DEC_LOW_LATCH: begin
                    word_strobe <= 1'b1;
                    state       <= emu_pkg::DEC_WORD_BUSY;
                end

                // Hold off until the loader has advanced the address
                emu_pkg::DEC_WORD_BUSY: begin
                    if (write_done) begin
                        if (remaining != '0) begin
                            state <= emu_pkg::DEC_WAIT_HIGH;
                        end else begin
                            state <= emu_pkg::DEC_NEXTCMD;
                        end
                    end
                end

                default: begin
                    state <= emu_pkg::DEC_NEXTCMD;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Payload capture

    // Only meaningful alongside their strobes
    always_ff @(posedge clk24MHz) begin
        if (state == emu_pkg::DEC_HIGH_LATCH) begin
            word[15:8] <= ft240x_d;
        end
        if (state == emu_pkg::DEC_LOW_LATCH) begin
            word[7:0] <= ft240x_d;
        end
        if (state == emu_pkg::DEC_GETCMD) begin
            // mm stored as is, 2 and 3 included
            mode_sel     <= emu_pkg::mode_t'(ft240x_d[1:0]);
            status_value <= (ft240x_d == emu_pkg::CMD_LED_ON);
        end
    end

endmodule

// ==== hdl/emu_pkg.sv ====
package emu_pkg;

    //////////////////////////////////////////////////
    // Bus widths

    // One byte on the FT240X FIFO bus
    typedef logic [7:0] fifo_byte_t;

    // One SRAM data word
    typedef logic [15:0] sram_word_t;

    // Word count field of a WRITE command
    typedef logic [3:0] word_count_t;

    //////////////////////////////////////////////////
    // Mode and state encodings

    // Values 2 and 3 are legal too: target owns the bus, SRAM outputs stay off
    typedef enum logic [1:0] {
        MODE_LOAD = 2'd0,
        MODE_RUN  = 2'd1
    } mode_t;

    // Command decoder FSM
    typedef enum logic [3:0] {
        DEC_NEXTCMD    = 4'd0,
        DEC_WAITCMD    = 4'd1,
        DEC_CMD_PRERX  = 4'd2,
        DEC_GETCMD     = 4'd3,
        DEC_WAIT_HIGH  = 4'd4,
        DEC_HIGH_REQ   = 4'd5,
        DEC_HIGH_LATCH = 4'd6,
        DEC_WAIT_LOW   = 4'd7,
        DEC_LOW_REQ    = 4'd8,
        DEC_LOW_LATCH  = 4'd9,
        DEC_WORD_BUSY  = 4'd10
    } decoder_state_t;

    // SRAM write sequence FSM
    typedef enum logic [1:0] {
        LD_IDLE    = 2'd0,
        LD_STROBE  = 2'd1,
        LD_RELEASE = 2'd2,
        LD_ADVANCE = 2'd3
    } loader_state_t;

    //////////////////////////////////////////////////
    // Command opcodes

    localparam fifo_byte_t  CMD_NOP             = 8'h00;
    localparam fifo_byte_t  CMD_ADDR_RESET      = 8'h01;
    localparam fifo_byte_t  CMD_LED_ON          = 8'h55;
    localparam fifo_byte_t  CMD_LED_OFF         = 8'hAA;
    // Upper nibble only, lower nibble carries an argument
    localparam logic [3:0]  CMD_SET_MODE_NIBBLE = 4'h1;
    localparam logic [3:0]  CMD_WRITE_NIBBLE    = 4'h2;

endpackage

// ==== hdl/eprom_emulator_top.sv ====
module eprom_emulator_top #(
    parameter int ADDR_WIDTH = 18
) (
    input  logic                  clk24MHz,
    input  logic                  rst_n,
    // FT240X FIFO receive side
    input  emu_pkg::fifo_byte_t   ft240x_d,
    input  logic                  ft240x_rxf,
    output logic                  ft240x_rd_n,
    // Target EPROM socket
    input  logic [ADDR_WIDTH-1:0] addr_bus,
    inout  wire emu_pkg::sram_word_t data_bus,
    input  logic                  tgt_ce_n,
    input  logic                  tgt_oel_n,
    input  logic                  tgt_oeh_n,
    // Target data buffer
    output logic                  target_dbusbuf_dir,
    output logic                  target_dbusbuf_en,
    // SRAM
    output logic [ADDR_WIDTH-1:0] sram_addr,
    output logic                  sram_cs_n,
    output logic                  sram_we_n,
    output logic                  sram_oe_n,
    output logic                  sram_ub_n,
    output logic                  sram_lb_n,
    // LEDs active high
    output logic                  led_red,
    output logic                  led_amber,
    output logic                  led_green
);

    // Decoder to loader
    logic                  addr_clear;
    logic                  word_strobe;
    emu_pkg::sram_word_t   word;
    logic                  write_done;

    // Decoder to mode control
    logic                  mode_strobe;
    emu_pkg::mode_t        mode_sel;
    logic                  status_strobe;
    logic                  status_value;

    // Loader to mode control
    emu_pkg::sram_word_t   write_word;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic                  write_pulse;

    //////////////////////////////////////////////////
    // Constant pins

    // SRAM always selected with both byte lanes enabled
    assign sram_cs_n          = 1'b0;
    assign sram_ub_n          = 1'b0;
    assign sram_lb_n          = 1'b0;
    // Buffer only ever drives toward the target
    assign target_dbusbuf_dir = 1'b1;

    //////////////////////////////////////////////////
    // Blocks

    command_decoder u_decoder (
        .clk24MHz      (clk24MHz),
        .rst_n         (rst_n),
        .ft240x_d      (ft240x_d),
        .ft240x_rxf    (ft240x_rxf),
        .ft240x_rd_n   (ft240x_rd_n),
        .write_done    (write_done),
        .addr_clear    (addr_clear),
        .word_strobe   (word_strobe),
        .word          (word),
        .mode_strobe   (mode_strobe),
        .mode_sel      (mode_sel),
        .status_strobe (status_strobe),
        .status_value  (status_value)
    );

    sram_loader #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_loader (
        .clk24MHz    (clk24MHz),
        .rst_n       (rst_n),
        .addr_clear  (addr_clear),
        .word_strobe (word_strobe),
        .word        (word),
        .write_word  (write_word),
        .load_addr   (load_addr),
        .write_pulse (write_pulse),
        .write_done  (write_done)
    );

    mode_control #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mode (
        .clk24MHz          (clk24MHz),
        .rst_n             (rst_n),
        .mode_strobe       (mode_strobe),
        .mode_sel          (mode_sel),
        .status_strobe     (status_strobe),
        .status_value      (status_value),
        .load_addr         (load_addr),
        .write_word        (write_word),
        .write_pulse       (write_pulse),
        .ft240x_rd_n       (ft240x_rd_n),
        .addr_bus          (addr_bus),
        .tgt_ce_n          (tgt_ce_n),
        .tgt_oel_n         (tgt_oel_n),
        .tgt_oeh_n         (tgt_oeh_n),
        .sram_addr         (sram_addr),
        .data_bus          (data_bus),
        .sram_we_n         (sram_we_n),
        .sram_oe_n         (sram_oe_n),
        .target_dbusbuf_en (target_dbusbuf_en),
        .led_red           (led_red),
        .led_amber         (led_amber),
        .led_green         (led_green)
    );

endmodule

// ==== hdl/mode_control.sv ====
module mode_control #(
    parameter int ADDR_WIDTH = 18
) (
    input  logic                  clk24MHz,
    input  logic                  rst_n,
    // Decoder commands
    input  logic                  mode_strobe,
    input  emu_pkg::mode_t        mode_sel,
    input  logic                  status_strobe,
    input  logic                  status_value,
    // Loader
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  emu_pkg::sram_word_t   write_word,
    input  logic                  write_pulse,
    // Activity indication
    input  logic                  ft240x_rd_n,
    // Target side
    input  logic [ADDR_WIDTH-1:0] addr_bus,
    input  logic                  tgt_ce_n,
    input  logic                  tgt_oel_n,
    input  logic                  tgt_oeh_n,
    // SRAM and buffer pins
    output logic [ADDR_WIDTH-1:0] sram_addr,
    inout  wire emu_pkg::sram_word_t data_bus,
    output logic                  sram_we_n,
    output logic                  sram_oe_n,
    output logic                  target_dbusbuf_en,
    output logic                  led_red,
    output logic                  led_amber,
    output logic                  led_green
);

    emu_pkg::mode_t mode;
    logic           status;

    //////////////////////////////////////////////////
    // Mode and status registers

    always_ff @(posedge clk24MHz) begin
        if (!rst_n) begin
            mode   <= emu_pkg::MODE_LOAD;
            status <= 1'b0;
        end else begin
            if (mode_strobe) begin
                mode <= mode_sel;
            end
            if (status_strobe) begin
                status <= status_value;
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus steering

    // LOAD owns address and data, otherwise the target does
    assign sram_addr = (mode == emu_pkg::MODE_LOAD) ? load_addr : addr_bus;
    assign data_bus  = (mode == emu_pkg::MODE_LOAD) ? write_word : 'z;

    // No writes reach the SRAM outside LOAD
    assign sram_we_n = !(write_pulse && mode == emu_pkg::MODE_LOAD);
    // Only RUN reads the SRAM, modes 2 and 3 keep it quiet
    assign sram_oe_n = (mode != emu_pkg::MODE_RUN);

    // Buffer opens on a target read cycle, active low
    assign target_dbusbuf_en = !(mode == emu_pkg::MODE_RUN && !tgt_ce_n &&
                                 (!tgt_oel_n || !tgt_oeh_n));

    //////////////////////////////////////////////////
    // LEDs

    // Red shows FIFO read activity
    assign led_red   = !ft240x_rd_n;
    assign led_amber = (mode == emu_pkg::MODE_LOAD);
    assign led_green = status;

endmodule

// ==== hdl/sram_loader.sv ====
module sram_loader #(
    parameter int ADDR_WIDTH = 18
) (
    input  logic                  clk24MHz,
    input  logic                  rst_n,
    // From the decoder
    input  logic                  addr_clear,
    input  logic                  word_strobe,
    input  emu_pkg::sram_word_t   word,
    // Toward the SRAM steering
    output emu_pkg::sram_word_t   write_word,
    output logic [ADDR_WIDTH-1:0] load_addr,
    output logic                  write_pulse,
    // Back to the decoder
    output logic                  write_done
);

    emu_pkg::loader_state_t state;

    //////////////////////////////////////////////////
    // Write sequence and address counter

    always_ff @(posedge clk24MHz) begin
        if (!rst_n) begin
            state     <= emu_pkg::LD_IDLE;
            load_addr <= '0;
        end else begin
            case (state)
                emu_pkg::LD_IDLE: begin
                    if (word_strobe) begin
                        state <= emu_pkg::LD_STROBE;
                    end
                end
                // WE# low for this one cycle
                emu_pkg::LD_STROBE: begin
                    state <= emu_pkg::LD_RELEASE;
                end
                // WE# back high before the address moves
                emu_pkg::LD_RELEASE: begin
                    state <= emu_pkg::LD_ADVANCE;
                end
                emu_pkg::LD_ADVANCE: begin
                    load_addr <= load_addr + 1'b1;
                    state     <= emu_pkg::LD_IDLE;
                end
                default: begin
                    state <= emu_pkg::LD_IDLE;
                end
            endcase

            // Address reset wins over the increment
            if (addr_clear) begin
                load_addr <= '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Write latch

    // Holds the word stable through STROBE and RELEASE
    always_ff @(posedge clk24MHz) begin
        if (word_strobe && state == emu_pkg::LD_IDLE) begin
            write_word <= word;
        end
    end

    assign write_pulse = (state == emu_pkg::LD_STROBE);
    // Counter steps on the edge that ends this cycle
    assign write_done  = (state == emu_pkg::LD_ADVANCE);

endmodule

// ==== src.f ====
hdl/emu_pkg.sv
hdl/command_decoder.sv
hdl/sram_loader.sv
hdl/mode_control.sv
hdl/eprom_emulator_top.sv
verification/tb_eprom_emulator.sv

// ==== verification/tb_eprom_emulator.sv ====
module tb_eprom_emulator;

    localparam int          ADDR_WIDTH     = 18;
    localparam int          HALF_PERIOD    = 10;
    localparam int          RESET_CYCLES   = 3;
    // Run limit is ten times the roughly 2000 cycles of traffic in all tests
    localparam int          TEST_CYCLES    = 2000;
    localparam int          TIMEOUT_CYCLES = 10 * TEST_CYCLES;
    localparam logic [15:0] LFSR_SEED      = 16'd84;
    // WE pulse, release and address step after the last word
    localparam int          LOADER_CYCLES  = 4;
    // Expected buffer enable in RUN indexed by {ce, oel, oeh}
    // Low only while CE# and at least one OE# are low
    localparam logic [7:0]  BUF_EN_RUN     = 8'b1111_1000;

    logic                  clk24MHz;
    logic                  rst_n;
    emu_pkg::fifo_byte_t   ft240x_d;
    logic                  ft240x_rxf;
    logic                  ft240x_rd_n;
    logic [ADDR_WIDTH-1:0] addr_bus;
    wire emu_pkg::sram_word_t data_bus;
    logic                  tgt_ce_n;
    logic                  tgt_oel_n;
    logic                  tgt_oeh_n;
    logic                  target_dbusbuf_dir;
    logic                  target_dbusbuf_en;
    logic [ADDR_WIDTH-1:0] sram_addr;
    logic                  sram_cs_n;
    logic                  sram_we_n;
    logic                  sram_oe_n;
    logic                  sram_ub_n;
    logic                  sram_lb_n;
    logic                  led_red;
    logic                  led_amber;
    logic                  led_green;

    // Host side byte stream and SRAM contents
    emu_pkg::fifo_byte_t   rx_queue[$];
    emu_pkg::sram_word_t   sram_mem[int];
    // Words expected in the SRAM in write order
    emu_pkg::sram_word_t   exp_words[$];
    int                    write_count = 0;
    logic                  rd_n_prev;
    logic [15:0]           lfsr_state;

    string                 test_name = "startup";
    int                    test_errors = 0;
    int                    total_errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    cycle_count = 0;

    eprom_emulator_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut (
        .clk24MHz           (clk24MHz),
        .rst_n              (rst_n),
        .ft240x_d           (ft240x_d),
        .ft240x_rxf         (ft240x_rxf),
        .ft240x_rd_n        (ft240x_rd_n),
        .addr_bus           (addr_bus),
        .data_bus           (data_bus),
        .tgt_ce_n           (tgt_ce_n),
        .tgt_oel_n          (tgt_oel_n),
        .tgt_oeh_n          (tgt_oeh_n),
        .target_dbusbuf_dir (target_dbusbuf_dir),
        .target_dbusbuf_en  (target_dbusbuf_en),
        .sram_addr          (sram_addr),
        .sram_cs_n          (sram_cs_n),
        .sram_we_n          (sram_we_n),
        .sram_oe_n          (sram_oe_n),
        .sram_ub_n          (sram_ub_n),
        .sram_lb_n          (sram_lb_n),
        .led_red            (led_red),
        .led_amber          (led_amber),
        .led_green          (led_green)
    );

    always #(HALF_PERIOD) clk24MHz = ~clk24MHz;

    // Run limit
    always @(posedge clk24MHz) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: no progress after %0d cycles in test %s", cycle_count, test_name);
            $display(">>> FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reporting and checks

    task automatic report_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("Error %s: %s expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_text(input string text);
        $display("Failure in %s: %s", test_name, text);
        test_errors++;
        total_errors++;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_value(what, expected, actual);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("Test %s ok", test_name);
        end else begin
            $display("Test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // Red LED mirrors FIFO read activity
    assert property (@(posedge clk24MHz) disable iff (!rst_n) led_red == !ft240x_rd_n)
        else report_value("led_red", !$sampled(ft240x_rd_n), $sampled(led_red));

    // WE# is a single-cycle pulse
    assert property (@(posedge clk24MHz) disable iff (!rst_n) $fell(sram_we_n) |=> sram_we_n)
        else report_text("sram_we_n stayed low for more than one cycle");

    // Writes only in LOAD and never while the SRAM drives the bus
    assert property (@(posedge clk24MHz) disable iff (!rst_n)
                     !sram_we_n |-> (led_amber && sram_oe_n))
        else report_text("sram_we_n went low outside LOAD mode");

    // Address i holds the i-th word while WE# is low
    always @(posedge clk24MHz) begin
        if (rst_n && !sram_we_n) begin
            if (write_count >= exp_words.size()) begin
                report_text("SRAM write with no word outstanding");
            end else begin
                check_value("data_bus during write", exp_words[write_count], data_bus);
                check_value("sram_addr during write", write_count, sram_addr);
            end
        end
    end

    //////////////////////////////////////////////////
    // FT240X and SRAM models

    // Pop on RD# rising and present the head byte while RD# is low
    always @(negedge clk24MHz) begin
        if (rd_n_prev === 1'b0 && ft240x_rd_n === 1'b1 && rx_queue.size() != 0) begin
            void'(rx_queue.pop_front());
        end
        rd_n_prev = ft240x_rd_n;
        ft240x_rxf <= (rx_queue.size() == 0);
        if (ft240x_rd_n === 1'b0 && rx_queue.size() != 0) begin
            ft240x_d <= rx_queue[0];
        end else begin
            ft240x_d <= 'x;
        end
    end

    // SRAM latches on the rising edge of WE#
    always @(posedge sram_we_n) begin
        if (rst_n === 1'b1) begin
            sram_mem[int'(sram_addr)] = data_bus;
            write_count++;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[15]};
        end
    endtask

    // Bytes enter the FIFO on a rising edge away from the model updates
    task automatic send_command(input emu_pkg::fifo_byte_t cmd);
        @(posedge clk24MHz);
        rx_queue.push_back(cmd);
    endtask

    // WRITE opcode then each word high byte first
    task automatic send_write(input emu_pkg::word_count_t nnnn, input int n_words,
                              input bit stored);
        logic [31:0] w;
        @(posedge clk24MHz);
        rx_queue.push_back({emu_pkg::CMD_WRITE_NIBBLE, nnnn});
        repeat (n_words) begin
            random_bits(16, w);
            if (stored) begin
                exp_words.push_back(w[15:0]);
            end
            rx_queue.push_back(w[15:8]);
            rx_queue.push_back(w[7:0]);
        end
    endtask

    // Last strobe lands one edge after the final pop
    task automatic wait_drained();
        do begin
            @(posedge clk24MHz);
        end while (rx_queue.size() != 0);
        @(negedge clk24MHz);
    endtask

    task automatic wait_writes(input int target);
        while (write_count < target) begin
            @(posedge clk24MHz);
        end
        @(negedge clk24MHz);
    endtask

    task automatic check_memory(input int first_addr, input int count);
        for (int a = first_addr; a < first_addr + count; a++) begin
            if (!sram_mem.exists(a)) begin
                report_text($sformatf("SRAM address %0d was never written", a));
            end else begin
                check_value($sformatf("sram[%0d]", a), exp_words[a], sram_mem[a]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Tests

    task automatic reset_defaults();
        begin_test("reset");
        @(posedge clk24MHz);
        check_value("ft240x_rd_n", 1'b1, ft240x_rd_n);
        check_value("sram_we_n", 1'b1, sram_we_n);
        check_value("sram_oe_n", 1'b1, sram_oe_n);
        check_value("led_red", 1'b0, led_red);
        check_value("led_green", 1'b0, led_green);
        check_value("led_amber", 1'b1, led_amber);
        check_value("target_dbusbuf_en", 1'b1, target_dbusbuf_en);
        check_value("target_dbusbuf_dir", 1'b1, target_dbusbuf_dir);
        check_value("sram_cs_n, ub_n, lb_n", 3'b000, {sram_cs_n, sram_ub_n, sram_lb_n});
        check_value("sram_addr", 0, sram_addr);
        end_test();
    endtask

    task automatic load_words();
        begin_test("load");
        send_command(emu_pkg::CMD_ADDR_RESET);
        send_command({emu_pkg::CMD_SET_MODE_NIBBLE, 2'b00, emu_pkg::MODE_LOAD});
        send_write(4'd5, 5, 1'b1);
        wait_writes(5);
        wait_drained();
        check_value("write count", 5, write_count);
        check_memory(0, 5);
        end_test();
    endtask

    // Zero count wraps to 16 and the address carries on from 5
    task automatic zero_count_wrap();
        begin_test("count_zero");
        send_write(4'd0, 16, 1'b1);
        wait_writes(21);
        wait_drained();
        check_value("write count", 21, write_count);
        check_memory(5, 16);
        end_test();
    endtask

    task automatic led_and_nop();
        begin_test("led_nop");
        send_command(emu_pkg::CMD_LED_ON);
        wait_drained();
        check_value("led_green after 0x55", 1'b1, led_green);
        // Unknown bytes act as NOP
        send_command(emu_pkg::CMD_NOP);
        send_command(8'h42);
        send_command(8'hFF);
        wait_drained();
        check_value("led_green after NOPs", 1'b1, led_green);
        check_value("led_amber after NOPs", 1'b1, led_amber);
        check_value("sram_addr after NOPs", 21, sram_addr);
        check_value("write count after NOPs", 21, write_count);
        send_command(emu_pkg::CMD_LED_OFF);
        wait_drained();
        check_value("led_green after 0xAA", 1'b0, led_green);
        end_test();
    endtask

    task automatic run_mode_steering();
        logic [31:0] a;
        begin_test("run");
        send_command({emu_pkg::CMD_SET_MODE_NIBBLE, 2'b00, emu_pkg::MODE_RUN});
        wait_drained();
        check_value("led_amber", 1'b0, led_amber);
        check_value("sram_oe_n", 1'b0, sram_oe_n);
        repeat (8) begin
            @(negedge clk24MHz);
            random_bits(ADDR_WIDTH, a);
            addr_bus = a[ADDR_WIDTH-1:0];
            @(posedge clk24MHz);
            check_value("sram_addr", a, sram_addr);
            check_value("data_bus", 16'hzzzz, data_bus);
        end
        // Open only on a target read in RUN
        for (int c = 0; c < 8; c++) begin
            @(negedge clk24MHz);
            {tgt_ce_n, tgt_oel_n, tgt_oeh_n} = c[2:0];
            @(posedge clk24MHz);
            check_value($sformatf("target_dbusbuf_en ce,oel,oeh=%03b", c[2:0]),
                        BUF_EN_RUN[c], target_dbusbuf_en);
        end
        // Mode 2 hands the bus to the target with the SRAM outputs off
        send_command({emu_pkg::CMD_SET_MODE_NIBBLE, 4'b0010});
        wait_drained();
        random_bits(ADDR_WIDTH, a);
        addr_bus = a[ADDR_WIDTH-1:0];
        {tgt_ce_n, tgt_oel_n, tgt_oeh_n} = 3'b000;
        @(posedge clk24MHz);
        check_value("sram_oe_n in mode 2", 1'b1, sram_oe_n);
        check_value("led_amber in mode 2", 1'b0, led_amber);
        check_value("sram_addr in mode 2", a, sram_addr);
        check_value("data_bus in mode 2", 16'hzzzz, data_bus);
        check_value("target_dbusbuf_en in mode 2", 1'b1, target_dbusbuf_en);
        end_test();
    endtask

    task automatic run_mode_write();
        begin_test("run_write");
        @(negedge clk24MHz);
        {tgt_ce_n, tgt_oel_n, tgt_oeh_n} = 3'b111;
        // Don't-care bits set and still RUN
        send_command({emu_pkg::CMD_SET_MODE_NIBBLE, 2'b11, emu_pkg::MODE_RUN});
        wait_drained();
        check_value("sram_oe_n", 1'b0, sram_oe_n);
        send_write(4'd2, 2, 1'b0);
        wait_drained();
        repeat (LOADER_CYCLES) @(negedge clk24MHz);
        check_value("write count", 21, write_count);
        check_value("sram_we_n", 1'b1, sram_we_n);
        end_test();
    endtask

    initial begin
        clk24MHz   = 1'b0;
        rst_n      = 1'b0;
        ft240x_d   = '0;
        ft240x_rxf = 1'b1;
        addr_bus   = '0;
        tgt_ce_n   = 1'b1;
        tgt_oel_n  = 1'b1;
        tgt_oeh_n  = 1'b1;
        rd_n_prev  = 1'b1;
        lfsr_state = LFSR_SEED;
        repeat (RESET_CYCLES) @(negedge clk24MHz);
        rst_n = 1'b1;

        reset_defaults();
        load_words();
        zero_count_wrap();
        led_and_nop();
        run_mode_steering();
        run_mode_write();

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
